// File: rtl/debug_pkg.sv
`default_nettype none

package debug_pkg;

    // Processor state seen through the debug probes
    typedef struct packed {
        logic [31:0] pc;            // Fetch PC
        logic [31:0] instruction;   // Instruction at pc
        logic [4:0]  reg_addr;      // Write-back register
        logic [31:0] reg_data;      // Write-back value
        logic [31:0] alu_result;    // EX stage result
    } debug_probe_t;

    // One-cycle snapshot requests from the buttons
    typedef struct packed {
        logic pc_inst;
        logic wb_reg;               // Register write-back frame
        logic alu;
    } debug_request_t;

    // Frame being emitted
    typedef enum logic [1:0] {
        kind_pc_inst,
        kind_reg,
        kind_alu
    } frame_kind_t;

    localparam logic [7:0] header_pc_inst = 8'h50;  // 'P'
    localparam logic [7:0] header_reg     = 8'h52;  // 'R'
    localparam logic [7:0] header_alu     = 8'h41;  // 'A'
    localparam logic [7:0] frame_end      = 8'h0a;  // Line feed

    // Bytes per frame, header and terminator included
    localparam int frame_len_pc_inst = 10;
    localparam int frame_len_reg     = 7;
    localparam int frame_len_alu     = 6;
    localparam int frame_max_bytes   = 10;
    localparam int frame_idx_width   = $clog2(frame_max_bytes);

    localparam int debounce_cycles    = 1024;   // About 20 us at 50 MHz
    localparam int debounce_cnt_width = $clog2(debounce_cycles);

    // Bit positions in the raw button vector
    localparam int num_buttons    = 5;
    localparam int btn_center_idx = 0;
    localparam int btn_up_idx     = 1;
    localparam int btn_down_idx   = 2;
    localparam int btn_left_idx   = 3;
    localparam int btn_right_idx  = 4;

endpackage

`default_nettype wire

// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    // 50 MHz / 115200 baud, rounded
    localparam int bit_cycles       = 434;
    localparam int bit_period_width = $clog2(bit_cycles);

    localparam int frame_bits      = 10;        // Start, 8 data, stop
    localparam int bit_index_width = $clog2(frame_bits);

    // Transmit buffer
    localparam int fifo_depth       = 16;
    localparam int fifo_ptr_width   = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);   // Holds 0..fifo_depth

endpackage

`default_nettype wire

// File: rtl/button_controller.sv
`timescale 1ns/1ps
`default_nettype none

module button_controller
    import debug_pkg::*;
(
    input  wire            clk_50mhz,
    input  wire            reset,
    input  wire            btn_center,      // Single step
    input  wire            btn_up,          // Run / pause
    input  wire            btn_down,        // PC and instruction frame
    input  wire            btn_left,        // Write-back register frame
    input  wire            btn_right,       // ALU result frame
    output debug_request_t request,
    output logic           step_pulse,
    output logic           continuous_mode
);

    logic [num_buttons-1:0] btn_raw;
    logic [num_buttons-1:0] btn_level;      // Debounced levels
    logic [num_buttons-1:0] btn_level_d;    // Previous levels
    logic [num_buttons-1:0] btn_rise;

    assign btn_raw[btn_center_idx] = btn_center;
    assign btn_raw[btn_up_idx]     = btn_up;
    assign btn_raw[btn_down_idx]   = btn_down;
    assign btn_raw[btn_left_idx]   = btn_left;
    assign btn_raw[btn_right_idx]  = btn_right;

    // One stability counter per button
    for (genvar i = 0; i < num_buttons; i++) begin : g_debounce
        logic [debounce_cnt_width-1:0] stable_cnt;
        logic                          level_q;

        always_ff @(posedge clk_50mhz or posedge reset) begin
            if (reset) begin
                stable_cnt <= '0;
                level_q    <= 1'b0;
            end else if (btn_raw[i] == level_q) begin
                stable_cnt <= '0;               // Bounce restarts the window
            end else if (stable_cnt == debounce_cnt_width'(debounce_cycles - 1)) begin
                stable_cnt <= '0;
                level_q    <= btn_raw[i];       // Stable long enough
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end

        assign btn_level[i] = level_q;
    end

    always_ff @(posedge clk_50mhz or posedge reset) begin
        if (reset) begin
            btn_level_d <= '0;
        end else begin
            btn_level_d <= btn_level;
        end
    end

    assign btn_rise = btn_level & ~btn_level_d;     // Press edges only

    // Run mode flips on every press of btn_up
    always_ff @(posedge clk_50mhz or posedge reset) begin
        if (reset) begin
            continuous_mode <= 1'b0;
        end else if (btn_rise[btn_up_idx]) begin
            continuous_mode <= ~continuous_mode;
        end
    end

    assign step_pulse      = btn_rise[btn_center_idx];
    assign request.pc_inst = btn_rise[btn_down_idx];
    assign request.wb_reg  = btn_rise[btn_left_idx];
    assign request.alu     = btn_rise[btn_right_idx];

endmodule

`default_nettype wire

// File: rtl/run_control.sv
`timescale 1ns/1ps
`default_nettype none

module run_control (
    input  wire  clk_50mhz,
    input  wire  reset,
    input  wire  step_pulse,
    input  wire  continuous_mode,
    output logic cpu_clk_enable
);

    typedef enum logic [1:0] {
        run_idle,
        run_enable,     // Step, enable cycle
        run_disable     // Step, recovery cycle
    } run_state_t;

    run_state_t state;

    always_ff @(posedge clk_50mhz or posedge reset) begin
        if (reset) begin
            state          <= run_idle;
            cpu_clk_enable <= 1'b0;
        end else begin
            case (state)
                run_idle: begin
                    cpu_clk_enable <= 1'b0;
                    if (step_pulse) begin
                        state <= run_enable;        // Step wins over run mode
                    end else if (continuous_mode) begin
                        cpu_clk_enable <= 1'b1;     // Free running
                    end
                end
                run_enable: begin
                    cpu_clk_enable <= 1'b1;         // Exactly one enable cycle
                    state          <= run_disable;
                end
                run_disable: begin
                    cpu_clk_enable <= 1'b0;
                    state          <= run_idle;
                end
                default: state <= run_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/debug_frame_builder.sv
`timescale 1ns/1ps
`default_nettype none

module debug_frame_builder
    import debug_pkg::*;
    import uart_pkg::*;
(
    input  wire            clk_50mhz,
    input  wire            reset,
    input  wire            debug_request_t request,
    input  wire            debug_probe_t   probe,
    output uart_byte_t     out_data,
    output logic           out_valid,
    input  wire            out_ready
);

    typedef enum logic [1:0] {
        fb_idle,
        fb_capture,     // Snapshot taken this cycle
        fb_send
    } fb_state_t;

    fb_state_t                    state;
    frame_kind_t                  kind;
    logic [frame_idx_width-1:0]   byte_idx;     // Byte currently offered
    logic [frame_idx_width-1:0]   last_idx;     // Terminator position
    logic [frame_max_bytes*8-1:0] frame_q;      // First byte in the top bits
    logic                         byte_taken;

    assign out_valid  = (state == fb_send);
    assign byte_taken = out_valid && out_ready;
    assign out_data   = frame_q[(frame_max_bytes - 1 - byte_idx) * 8 +: 8];

    always_ff @(posedge clk_50mhz or posedge reset) begin
        if (reset) begin
            state    <= fb_idle;
            kind     <= kind_pc_inst;
            byte_idx <= '0;
            last_idx <= '0;
        end else begin
            case (state)
                fb_idle: begin
                    byte_idx <= '0;
                    // Fixed priority when requests coincide
                    if (request.pc_inst) begin
                        kind  <= kind_pc_inst;
                        state <= fb_capture;
                    end else if (request.wb_reg) begin
                        kind  <= kind_reg;
                        state <= fb_capture;
                    end else if (request.alu) begin
                        kind  <= kind_alu;
                        state <= fb_capture;
                    end
                end
                fb_capture: begin
                    state <= fb_send;
                    case (kind)
                        kind_pc_inst: last_idx <= frame_idx_width'(frame_len_pc_inst - 1);
                        kind_reg:     last_idx <= frame_idx_width'(frame_len_reg - 1);
                        kind_alu:     last_idx <= frame_idx_width'(frame_len_alu - 1);
                        default:      last_idx <= '0;
                    endcase
                end
                fb_send: begin
                    // Stalls here while the FIFO is full
                    if (byte_taken) begin
                        if (byte_idx == last_idx) begin
                            state <= fb_idle;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: state <= fb_idle;
            endcase
        end
    end

    // Snapshot, laid out in wire order, unused tail zero
    always_ff @(posedge clk_50mhz) begin
        if (state == fb_capture) begin
            case (kind)
                kind_pc_inst: frame_q <= {header_pc_inst, probe.pc, probe.instruction,
                                          frame_end};
                kind_reg:     frame_q <= {header_reg, 3'b000, probe.reg_addr, probe.reg_data,
                                          frame_end, 24'h0};
                default:      frame_q <= {header_alu, probe.alu_result, frame_end, 32'h0};
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
    import uart_pkg::*;
(
    input  wire        clk_50mhz,
    input  wire        reset,
    input  wire        uart_byte_t push_data,
    input  wire        push_valid,
    output logic       push_ready,
    output uart_byte_t pop_data,
    output logic       pop_valid,
    input  wire        pop_ready
);

    uart_byte_t                  mem [fifo_depth];
    logic [fifo_ptr_width-1:0]   wr_ptr;
    logic [fifo_ptr_width-1:0]   rd_ptr;
    logic [fifo_count_width-1:0] count;     // Entries held
    logic                        do_push;
    logic                        do_pop;

    assign push_ready = (count != fifo_count_width'(fifo_depth));   // Not full
    assign pop_valid  = (count != '0);                              // Not empty
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;
    assign pop_data   = mem[rd_ptr];    // Head of queue

    always_ff @(posedge clk_50mhz) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_50mhz or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire  clk_50mhz,
    input  wire  reset,
    input  wire  uart_byte_t in_data,
    input  wire  in_valid,
    output logic in_ready,
    output logic tx             // Serial line, idles high
);

    logic                         busy;
    logic [$bits(uart_byte_t):0]  shift_q;      // Remaining data bits, stop bit on top
    logic [bit_index_width-1:0]   bit_idx;      // 0 is the start bit
    logic [bit_period_width-1:0]  period_cnt;
    logic                         period_done;

    assign in_ready    = ~busy;
    assign period_done = (period_cnt == bit_period_width'(bit_cycles - 1));

    always_ff @(posedge clk_50mhz or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            tx         <= 1'b1;
            bit_idx    <= '0;
            period_cnt <= '0;
        end else if (!busy) begin
            if (in_valid) begin
                busy       <= 1'b1;
                tx         <= 1'b0;         // Start bit
                bit_idx    <= '0;
                period_cnt <= '0;
            end
        end else if (period_done) begin
            period_cnt <= '0;
            if (bit_idx == bit_index_width'(frame_bits - 1)) begin
                busy <= 1'b0;               // Stop bit finished
                tx   <= 1'b1;
            end else begin
                tx      <= shift_q[0];      // LSB first
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (!busy && in_valid) begin
            shift_q <= {1'b1, in_data};
        end else if (busy && period_done) begin
            shift_q <= {1'b1, shift_q[$bits(uart_byte_t):1]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/debug_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module debug_uart_top
    import debug_pkg::*;
    import uart_pkg::*;
(
    input  wire  clk_50mhz,
    input  wire  reset,             // Board reset, async
    input  wire  btn_center,
    input  wire  btn_up,
    input  wire  btn_down,
    input  wire  btn_left,
    input  wire  btn_right,
    input  wire  debug_probe_t probe,
    output logic cpu_clk_enable,
    output logic uart_tx_out
);

    logic [2:0]     reset_sync;
    logic           internal_reset;
    debug_request_t request;
    logic           step_pulse;
    logic           continuous_mode;
    uart_byte_t     push_data;
    logic           push_valid;
    logic           push_ready;
    uart_byte_t     pop_data;
    logic           pop_valid;
    logic           pop_ready;

    // Assert at once, release after three clean edges
    always_ff @(posedge clk_50mhz or posedge reset) begin
        if (reset) begin
            reset_sync <= 3'b111;
        end else begin
            reset_sync <= {reset_sync[1:0], 1'b0};
        end
    end

    assign internal_reset = reset_sync[2];

    button_controller button_ctrl (
        .clk_50mhz       (clk_50mhz),
        .reset           (internal_reset),
        .btn_center      (btn_center),
        .btn_up          (btn_up),
        .btn_down        (btn_down),
        .btn_left        (btn_left),
        .btn_right       (btn_right),
        .request         (request),
        .step_pulse      (step_pulse),
        .continuous_mode (continuous_mode)
    );

    run_control run_ctrl (
        .clk_50mhz       (clk_50mhz),
        .reset           (internal_reset),
        .step_pulse      (step_pulse),
        .continuous_mode (continuous_mode),
        .cpu_clk_enable  (cpu_clk_enable)
    );

    // Producer
    debug_frame_builder frame_builder (
        .clk_50mhz (clk_50mhz),
        .reset     (internal_reset),
        .request   (request),
        .probe     (probe),
        .out_data  (push_data),
        .out_valid (push_valid),
        .out_ready (push_ready)
    );

    byte_fifo tx_fifo (
        .clk_50mhz  (clk_50mhz),
        .reset      (internal_reset),
        .push_data  (push_data),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .pop_data   (pop_data),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready)
    );

    // Consumer, drains one byte per serial frame
    uart_tx tx (
        .clk_50mhz (clk_50mhz),
        .reset     (internal_reset),
        .in_data   (pop_data),
        .in_valid  (pop_valid),
        .in_ready  (pop_ready),
        .tx        (uart_tx_out)
    );

endmodule

`default_nettype wire

// File: dv/debug_uart_properties.sv
`timescale 1ns/1ps
`default_nettype none

module debug_uart_properties
    import uart_pkg::*;
(
    input wire                        clk_50mhz,
    input wire                        reset,
    input wire                        tx_busy,
    input wire                        uart_tx_out,
    input wire                        push_valid,
    input wire                        push_ready,
    input wire uart_byte_t            push_data,
    input wire                        cpu_clk_enable,
    input wire                        continuous_mode,
    input wire [fifo_count_width-1:0] fifo_count
);

    int assert_failures = 0;    // Failed property count

    tx_idle_high: assert property (@(posedge clk_50mhz) disable iff (reset)
        !tx_busy |-> uart_tx_out)
        else begin
            assert_failures++;
            $error("uart_tx_out low while the transmitter is idle");
        end

    // Stalled producer keeps its byte
    push_held: assert property (@(posedge clk_50mhz) disable iff (reset)
        push_valid && !push_ready |=> push_valid && $stable(push_data))
        else begin
            assert_failures++;
            $error("Builder dropped or changed a stalled byte");
        end

    // Enable follows run mode one cycle late
    single_enable: assert property (@(posedge clk_50mhz) disable iff (reset)
        cpu_clk_enable && $past(cpu_clk_enable) |-> $past(continuous_mode))
        else begin
            assert_failures++;
            $error("cpu_clk_enable high twice outside continuous mode");
        end

    fifo_bound: assert property (@(posedge clk_50mhz) disable iff (reset)
        fifo_count <= fifo_count_width'(fifo_depth))
        else begin
            assert_failures++;
            $error("FIFO count above its depth");
        end

endmodule

bind debug_uart_top debug_uart_properties props (
    .clk_50mhz       (clk_50mhz),
    .reset           (internal_reset),
    .tx_busy         (tx.busy),
    .uart_tx_out     (uart_tx_out),
    .push_valid      (push_valid),
    .push_ready      (push_ready),
    .push_data       (push_data),
    .cpu_clk_enable  (cpu_clk_enable),
    .continuous_mode (continuous_mode),
    .fifo_count      (tx_fifo.count)
);

`default_nettype wire

// File: dv/debug_uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module debug_uart_tb
    import debug_pkg::*;
    import uart_pkg::*;
();

    logic                   clk_50mhz = 1'b0;
    logic                   reset;
    logic [num_buttons-1:0] buttons;        // Raw button levels
    debug_probe_t           probe;
    logic                   cpu_clk_enable;
    logic                   uart_tx_out;

    // Test table from the data file
    int           op_q[$];
    debug_probe_t probe_q[$];
    int           bytes_q[$];
    int           enable_q[$];              // Pulse count, or level for run toggle
    logic         tests_loaded = 1'b0;

    uart_byte_t   rx_bytes[$];              // Bytes rebuilt from the serial line
    uart_byte_t   expected_q[$];
    logic         rx_enable = 1'b0;
    int           enable_count = 0;

    always #10 clk_50mhz = ~clk_50mhz;      // 50 MHz

    debug_uart_top dut (
        .clk_50mhz      (clk_50mhz),
        .reset          (reset),
        .btn_center     (buttons[btn_center_idx]),
        .btn_up         (buttons[btn_up_idx]),
        .btn_down       (buttons[btn_down_idx]),
        .btn_left       (buttons[btn_left_idx]),
        .btn_right      (buttons[btn_right_idx]),
        .probe          (probe),
        .cpu_clk_enable (cpu_clk_enable),
        .uart_tx_out    (uart_tx_out)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_byte(input string name, input uart_byte_t expected,
                              input uart_byte_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t ns: %s expected %02h, actual %02h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_enable(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t ns: %s expected %b, actual %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abort_run($sformatf("** Error at %0t ns: %s expected %0d, actual %0d",
                                $time, name, expected, actual));
        end
    endtask

    function automatic int press_hold_cycles();
        return debounce_cycles + 64;        // Window plus margin
    endfunction

    // Two press windows, a full frame and the quiet check, doubled
    function automatic longint test_budget_cycles();
        return 2 * (4 * press_hold_cycles() + (frame_max_bytes + 2) * frame_bits * bit_cycles);
    endfunction

    task automatic load_tests();
        int          fd;
        string       line;
        int          op;
        int          nbytes;
        int          nenable;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [7:0]  raddr;
        logic [31:0] rdata;
        logic [31:0] alu;
        debug_probe_t p;
        fd = $fopen("dv/debug_uart_input.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the stimulus file dv/debug_uart_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;                   // Blank or column notes
            end
            if ($sscanf(line, "%h %h %h %h %h %h %h %h", op, pc, instr, raddr, rdata, alu,
                        nbytes, nenable) != 8) begin
                abort_run($sformatf("Malformed stimulus line: %s", line));
            end
            p.pc          = pc;
            p.instruction = instr;
            p.reg_addr    = raddr[4:0];
            p.reg_data    = rdata;
            p.alu_result  = alu;
            op_q.push_back(op);
            probe_q.push_back(p);
            bytes_q.push_back(nbytes);
            enable_q.push_back(nenable);
        end
        $fclose(fd);
        tests_loaded = 1'b1;
    endtask

    task automatic push_word(input logic [31:0] w);
        for (int b = 3; b >= 0; b--) begin
            expected_q.push_back(w[b*8 +: 8]);      // MSB first
        end
    endtask

    // Frame layout: header, fields, line feed
    task automatic build_expected(input int op, input debug_probe_t p);
        expected_q.delete();
        case (op)
            3: begin
                expected_q.push_back(header_pc_inst);
                push_word(p.pc);
                push_word(p.instruction);
            end
            4: begin
                expected_q.push_back(header_reg);
                expected_q.push_back({3'b000, p.reg_addr});  // Zero extended
                push_word(p.reg_data);
            end
            default: begin
                expected_q.push_back(header_alu);
                push_word(p.alu_result);
            end
        endcase
        expected_q.push_back(frame_end);
    endtask

    task automatic press_button(input int idx);
        @(posedge clk_50mhz);
        buttons[idx] <= 1'b1;
        repeat (press_hold_cycles()) @(posedge clk_50mhz);
        buttons[idx] <= 1'b0;
        repeat (press_hold_cycles()) @(posedge clk_50mhz);  // Debounced release
    endtask

    task automatic glitch_buttons();
        @(posedge clk_50mhz);
        buttons <= '1;
        repeat (debounce_cycles / 2) @(posedge clk_50mhz);  // Too short to count
        buttons <= '0;
        repeat (press_hold_cycles()) @(posedge clk_50mhz);
    endtask

    task automatic run_test(input int t);
        int op;
        op = op_q[t];
        @(posedge clk_50mhz);
        probe <= probe_q[t];
        enable_count = 0;
        rx_bytes.delete();
        case (op)
            0: begin
                @(negedge clk_50mhz);
                check_enable("cpu_clk_enable", 1'b0, cpu_clk_enable);
                check_enable("uart_tx_out", 1'b1, uart_tx_out);   // Idle line
            end
            1: press_button(btn_center_idx);
            2: press_button(btn_up_idx);
            3: press_button(btn_down_idx);
            4: press_button(btn_left_idx);
            5: press_button(btn_right_idx);
            6: glitch_buttons();
            default: abort_run($sformatf("Unknown operation %0d in test %0d", op, t));
        endcase
        if (op == 2) begin
            @(negedge clk_50mhz);
            check_enable("cpu_clk_enable", enable_q[t][0], cpu_clk_enable);
        end else if (op != 0) begin
            while (rx_bytes.size() < bytes_q[t]) begin
                @(posedge clk_50mhz);
            end
            repeat (2 * frame_bits * bit_cycles) @(posedge clk_50mhz);  // No extra bytes
            check_count("uart byte count", bytes_q[t], rx_bytes.size());
            check_count("cpu_clk_enable cycles", enable_q[t], enable_count);
            if (op >= 3 && op <= 5) begin
                build_expected(op, probe_q[t]);
                check_count("frame length", bytes_q[t], expected_q.size());
                foreach (expected_q[i]) begin
                    check_byte($sformatf("uart byte %0d", i), expected_q[i], rx_bytes[i]);
                end
            end
        end
    endtask

    always @(negedge clk_50mhz) begin
        if (cpu_clk_enable === 1'b1) begin
            enable_count = enable_count + 1;
        end
    end

    always @(negedge clk_50mhz) begin
        if (dut.props.assert_failures != 0) begin
            abort_run("A bound property check fired");
        end
    end

    // 8N1 receiver, samples mid bit
    initial begin : uart_receiver
        uart_byte_t rx_data;
        wait (rx_enable);
        forever begin
            @(negedge uart_tx_out);
            repeat (bit_cycles / 2) @(negedge clk_50mhz);
            if (uart_tx_out !== 1'b0) begin
                abort_run("UART receiver saw a start bit that did not last");
            end
            for (int i = 0; i < 8; i++) begin
                repeat (bit_cycles) @(negedge clk_50mhz);
                rx_data[i] = uart_tx_out;               // LSB first
            end
            repeat (bit_cycles) @(negedge clk_50mhz);
            if (uart_tx_out !== 1'b1) begin
                abort_run("UART receiver found no stop bit");
            end
            rx_bytes.push_back(rx_data);
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (tests_loaded);
        limit_ns = longint'(op_q.size() + 1) * test_budget_cycles() * 20;
        #(limit_ns);
        abort_run($sformatf("Watchdog expired after %0d ns, a test never finished", limit_ns));
    end

    initial begin : main_sequence
        reset   = 1'b1;
        buttons = '0;
        probe   = '0;
        load_tests();
        repeat (4) @(posedge clk_50mhz);
        reset <= 1'b0;
        repeat (4) @(posedge clk_50mhz);    // Let the synchronizer release
        rx_enable = 1'b1;
        for (int t = 0; t < op_q.size(); t++) begin
            run_test(t);
        end
        if (dut.props.assert_failures == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("Property checks reported failures");
        end
    end

endmodule

`default_nettype wire

// File: dv/debug_uart_input.txt
# op pc instruction reg_addr reg_data alu_result byte_count enable_count_or_level (all hex)
# op: 0 reset state, 1 step, 2 run toggle, 3 P frame, 4 R frame, 5 A frame, 6 glitch
0 00000000 00000000 00 00000000 00000000 0 0
1 00000000 00000000 00 00000000 00000000 0 1
2 00000000 00000000 00 00000000 00000000 0 1
2 00000000 00000000 00 00000000 00000000 0 0
3 00400010 00a28293 05 0000002a 00000054 a 0
4 00400014 fe010113 1f deadbeef 12345678 7 0
5 00400018 00b50533 0a 0000000a 8badf00d 6 0
6 00400018 00b50533 0a 0000000a 8badf00d 0 0
1 0040001c 00000013 00 00000000 00000000 0 1
3 ffff0000 ffffffff 1f 80000001 0a0a0a0a a 0
4 00000000 00000000 01 0a0a0a0a 00000000 7 0
5 12345678 9abcdef0 10 00000000 ffffffff 6 0
6 00000000 00000000 00 00000000 00000000 0 0

// File: src.f
rtl/debug_pkg.sv
rtl/uart_pkg.sv
rtl/button_controller.sv
rtl/run_control.sv
rtl/debug_frame_builder.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/debug_uart_top.sv
dv/debug_uart_properties.sv
dv/debug_uart_tb.sv
